/* source/rom_load_pkg.sv */
// shared memory map, header byte positions, unscramble tables and request structs for the loader
package rom_load_pkg;

    // header layout, byte addresses in the download stream
    localparam logic [24:0] header_len  = 25'd64;
    localparam logic [24:0] start_bytes = 25'd8;   // four 16-bit pointers, low byte first
    localparam logic [24:0] cfg_first   = 25'd8;
    localparam logic [24:0] cfg_last    = 25'd39;
    localparam logic [24:0] cfg_byte    = 25'd39;  // bits 7:6 = unscramble enable, parity
    localparam logic [24:0] joy_byte    = 25'd40;  // bits 1:0 = joystick mode
    localparam logic [24:0] key_first   = 25'd44;
    localparam logic [24:0] key_last    = 25'd63;

    // sdram word offsets of each region inside its bank
    localparam logic [21:0] cpu_offset = 22'h00_0000;
    localparam logic [21:0] snd_offset = 22'h08_0000;
    localparam logic [21:0] pcm_offset = 22'h0A_0000;
    localparam logic [21:0] gfx_offset = 22'h00_0000;  // gfx owns bank 3 alone

    localparam int eeprom_aw = 7;

    // cpu byte unscramble tables, indexed by input bit
    // set mask applies when the bit is 1, clear mask when it is 0
    localparam logic [7:0][7:0] scramble_set_mask = {
        8'h00, 8'h08, 8'h06, 8'h40, 8'h00, 8'h01, 8'h21, 8'h04
    };
    localparam logic [7:0][7:0] scramble_clr_mask = {
        8'h88, 8'h00, 8'h00, 8'h00, 8'h50, 8'h00, 8'h00, 8'h00
    };

    typedef enum logic [2:0] {
        reg_none,   // header bytes
        reg_cpu,
        reg_snd,
        reg_pcm,
        reg_gfx,
        reg_qsnd    // internal sound rom, not in sdram
    } region_t;

    // kb pointers, snd sits in the low bits as it arrives first
    typedef struct packed {
        logic [15:0] qsnd;
        logic [15:0] gfx;
        logic [15:0] pcm;
        logic [15:0] snd;
    } region_starts_t;

    typedef struct packed {
        logic       unscramble;
        logic       parity;
        logic [1:0] joymode;
    } load_cfg_t;

    typedef struct packed {
        logic [21:0] addr;
        logic [7:0]  data;
        logic [1:0]  mask;   // active low byte lanes
        logic [1:0]  bank;
        region_t     region;
    } prog_req_t;

endpackage

/* source/rom_header_regs.sv */
// captures region pointers and config bytes from the image header, pulses the cfg and key strobes
module rom_header_regs (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        downloading,
    input  logic [24:0]                 ioctl_addr,
    input  logic [7:0]                  ioctl_data,
    input  logic                        ioctl_wr,     // header writes only
    output rom_load_pkg::region_starts_t starts,
    output rom_load_pkg::load_cfg_t     cfg,
    output logic                        cfg_we,
    output logic                        cps2_key_we
);
    import rom_load_pkg::*;

    logic is_start;
    logic in_cfg;
    logic in_key;

    assign is_start = ioctl_addr < start_bytes;
    assign in_cfg   = ioctl_addr >= cfg_first && ioctl_addr <= cfg_last;
    assign in_key   = ioctl_addr >= key_first && ioctl_addr <= key_last;

    // pointer bytes shift in from the top, so byte 0 settles in snd[7:0]
    always_ff @(posedge clk) begin
        if (ioctl_wr && is_start) begin
            starts <= {ioctl_data, starts[$bits(starts)-1:8]};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg         <= '0;
            cfg_we      <= 1'b0;
            cps2_key_we <= 1'b0;
        end else begin
            cfg_we      <= ioctl_wr && in_cfg;   // one pulse per config byte
            cps2_key_we <= ioctl_wr && in_key;
            if (ioctl_wr && ioctl_addr == cfg_byte) begin
                cfg.unscramble <= ioctl_data[7];
                cfg.parity     <= ioctl_data[6];
            end
            if (ioctl_wr && ioctl_addr == joy_byte) begin
                cfg.joymode <= ioctl_data[1:0];
            end
            // next image must set the flag again
            if (!downloading) begin
                cfg.unscramble <= 1'b0;
            end
        end
    end

    // config and key ranges are disjoint in the header
    a_strobe_excl: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(cfg_we && cps2_key_we)
    ) else $error("cfg_we and cps2_key_we high in the same cycle");

endmodule

/* source/rom_region_map.sv */
// decodes a bulk byte address into its region, sdram word address, lane mask and bank
module rom_region_map (
    input  logic [24:0]                  ioctl_addr,
    input  rom_load_pkg::region_starts_t starts,
    input  rom_load_pkg::load_cfg_t      cfg,
    output rom_load_pkg::prog_req_t      req,
    output logic                         unscramble_hit
);
    import rom_load_pkg::*;

    logic [24:0] bulk_addr;
    logic [15:0] kb_idx;       // 1 KB block index of the bulk address
    logic [24:0] region_base;
    logic [24:0] rel_addr;
    logic [21:0] region_offs;
    region_t     region;
    logic        is_hdr;

    assign is_hdr    = ioctl_addr < header_len;
    assign bulk_addr = ioctl_addr - header_len;
    assign kb_idx    = {1'b0, bulk_addr[24:10]};

    // regions are laid out back to back in pointer order
    always_comb begin
        if (is_hdr) begin
            region = reg_none;
        end else if (kb_idx < starts.snd) begin
            region = reg_cpu;
        end else if (kb_idx < starts.pcm) begin
            region = reg_snd;
        end else if (kb_idx < starts.gfx) begin
            region = reg_pcm;
        end else if (kb_idx < starts.qsnd) begin
            region = reg_gfx;
        end else begin
            region = reg_qsnd;
        end
    end

    always_comb begin
        region_base = '0;
        region_offs = cpu_offset;
        case (region)
            reg_snd: begin
                region_base = {starts.snd[14:0], 10'd0};
                region_offs = snd_offset;
            end
            reg_pcm: begin
                region_base = {starts.pcm[14:0], 10'd0};
                region_offs = pcm_offset;
            end
            reg_gfx: begin
                region_base = {starts.gfx[14:0], 10'd0};
                region_offs = gfx_offset;
            end
            reg_qsnd: begin
                region_base = {starts.qsnd[14:0], 10'd0};
            end
            default: ;  // cpu starts at bulk byte 0
        endcase
    end

    assign rel_addr = bulk_addr - region_base;

    always_comb begin
        req        = '0;       // data joins later from the unscrambler
        req.region = region;
        req.mask   = bulk_addr[0] ? 2'b01 : 2'b10;  // low lane on even bytes
        case (region)
            reg_cpu:  req.bank = 2'd0;
            reg_gfx:  req.bank = 2'd3;
            default:  req.bank = 2'd1;
        endcase
        if (region == reg_qsnd) begin
            req.addr = {9'd0, rel_addr[12:0]};  // internal rom is byte wide, 8 KB
        end else begin
            req.addr = rel_addr[22:1] + region_offs;
        end
    end

    // upper half of the cpu rom, one lane only, picked by the parity bit
    assign unscramble_hit = cfg.unscramble && region == reg_cpu && bulk_addr[19]
                            && (bulk_addr[0] ^ cfg.parity);

endmodule

/* source/byte_unscramble.sv */
// undoes the bitwise cpu rom scrambling of one byte when the region map flags a hit
module byte_unscramble (
    input  logic [7:0] raw,
    input  logic       hit,
    output logic [7:0] data
);
    import rom_load_pkg::*;

    logic [7:0] mixed;

    // every input bit contributes one of two xor terms
    always_comb begin
        mixed = 8'd0;
        for (int i = 0; i < 8; i++) begin
            if (raw[i]) begin
                mixed = mixed ^ scramble_set_mask[i];
            end else begin
                mixed = mixed ^ scramble_clr_mask[i];
            end
        end
    end

    assign data = hit ? mixed : raw;  // pass through outside the scrambled area

endmodule

/* source/rom_prog_writer.sv */
// registers one bulk write request and holds prog_we until sdram acknowledges, pulses prom_we
module rom_prog_writer (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    downloading,
    input  logic                    bulk_wr,
    input  rom_load_pkg::prog_req_t req,
    input  logic                    prog_rdy,
    output logic [21:0]             prog_addr,
    output logic [15:0]             prog_data,
    output logic [1:0]              prog_mask,
    output logic [1:0]              prog_ba,
    output logic                    prog_we,
    output logic                    prom_we
);
    import rom_load_pkg::*;

    prog_req_t req_q;
    logic      is_prom;

    assign is_prom = req.region == reg_qsnd;

    always_ff @(posedge clk) begin
        if (bulk_wr) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= bulk_wr && is_prom;    // internal rom takes the byte at once
            if (bulk_wr && !is_prom) begin
                prog_we <= 1'b1;
            end else if (prog_rdy || !downloading) begin
                prog_we <= 1'b0;              // released the cycle after the ack
            end
        end
    end

    assign prog_addr = req_q.addr;
    assign prog_data = {2{req_q.data}};      // same byte on both lanes, mask picks one
    assign prog_mask = req_q.mask;
    assign prog_ba   = req_q.bank;

    // host has to wait for the ack before the next bulk byte
    a_no_overrun: assert property (
        @(posedge clk) disable iff (!arst_n)
        bulk_wr |-> !prog_we || prog_rdy
    ) else $error("bulk write while sdram write still pending");

    a_addr_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        prog_we && !prog_rdy |=> $stable(prog_addr)
    ) else $error("prog_addr changed while prog_we held");

endmodule

/* source/nvram_dump_port.sv */
// bridges the 16-bit eeprom to the byte stream for saving and restoring nvram contents
module nvram_dump_port (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [24:0]                       ioctl_addr,
    input  logic [7:0]                        ioctl_data,
    input  logic                              ioctl_wr,
    input  logic                              ioctl_ram,
    input  logic [15:0]                       dump_dout,
    output logic [rom_load_pkg::eeprom_aw-1:0] dump_addr,
    output logic [15:0]                       dump_din,
    output logic                              dump_we,
    output logic [7:0]                        ioctl_data2sd
);
    import rom_load_pkg::*;

    logic nv_wr;

    assign nv_wr     = ioctl_wr && ioctl_ram;
    assign dump_addr = ioctl_addr[eeprom_aw:1];   // two bytes per eeprom word

    // only the addressed lane changes, the other keeps the previous byte
    always_ff @(posedge clk) begin
        if (nv_wr) begin
            if (ioctl_addr[0]) begin
                dump_din[15:8] <= ioctl_data;
            end else begin
                dump_din[7:0] <= ioctl_data;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dump_we <= 1'b0;
        end else begin
            dump_we <= nv_wr;
        end
    end

    assign ioctl_data2sd = ioctl_addr[0] ? dump_dout[15:8] : dump_dout[7:0];  // read path

endmodule

/* source/rom_loader_top.sv */
// rom download stage top, splits host writes between header, sdram, internal rom and eeprom paths
module rom_loader_top (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              downloading,
    input  logic [24:0]                       ioctl_addr,
    input  logic [7:0]                        ioctl_data,
    input  logic                              ioctl_wr,
    input  logic                              ioctl_ram,
    output logic [7:0]                        ioctl_data2sd,
    output logic [21:0]                       prog_addr,
    output logic [15:0]                       prog_data,
    output logic [1:0]                        prog_mask,
    output logic [1:0]                        prog_ba,
    output logic                              prog_we,
    output logic                              prom_we,
    input  logic                              prog_rdy,
    output logic                              cfg_we,
    output logic                              cps2_key_we,
    output logic [1:0]                        joymode,
    output logic [15:0]                       dump_din,
    input  logic [15:0]                       dump_dout,
    output logic [rom_load_pkg::eeprom_aw-1:0] dump_addr,
    output logic                              dump_we
);
    import rom_load_pkg::*;

    region_starts_t starts;
    load_cfg_t      cfg;
    prog_req_t      map_req;
    prog_req_t      wr_req;
    logic           unscramble_hit;
    logic [7:0]     prog_byte;
    logic           hdr_wr;
    logic           bulk_wr;

    // eeprom bytes never reach the header or the sdram path
    assign hdr_wr  = ioctl_wr && !ioctl_ram && ioctl_addr < header_len;
    assign bulk_wr = ioctl_wr && !ioctl_ram && ioctl_addr >= header_len;
    assign joymode = cfg.joymode;

    rom_header_regs u_header (
        .clk, .arst_n, .downloading, .ioctl_addr, .ioctl_data,
        .ioctl_wr (hdr_wr),
        .starts, .cfg, .cfg_we, .cps2_key_we
    );

    rom_region_map u_map (
        .ioctl_addr, .starts, .cfg,
        .req (map_req),
        .unscramble_hit
    );

    byte_unscramble u_unscramble (
        .raw  (ioctl_data),
        .hit  (unscramble_hit),
        .data (prog_byte)
    );

    always_comb begin
        wr_req      = map_req;
        wr_req.data = prog_byte;   // map leaves the data field empty
    end

    rom_prog_writer u_writer (
        .clk, .arst_n, .downloading, .bulk_wr,
        .req (wr_req),
        .prog_rdy, .prog_addr, .prog_data, .prog_mask, .prog_ba, .prog_we, .prom_we
    );

    nvram_dump_port u_nvram (
        .clk, .arst_n, .ioctl_addr, .ioctl_data, .ioctl_wr, .ioctl_ram,
        .dump_dout, .dump_addr, .dump_din, .dump_we, .ioctl_data2sd
    );

endmodule

/* sim/clock_gen.sv */
// testbench clock and reset source, 20 unit period with reset held low for the first 16 cycles
module clock_gen (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;   // released on a rising edge
    end

endmodule

/* sim/rom_loader_checker.sv */
// testbench monitor for the rom loader, predicts every write from the byte stream and counts errors
module rom_loader_checker (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_data,
    input  logic        ioctl_wr,
    input  logic        ioctl_ram,
    input  logic [7:0]  ioctl_data2sd,
    input  logic [21:0] prog_addr,
    input  logic [15:0] prog_data,
    input  logic [1:0]  prog_mask,
    input  logic [1:0]  prog_ba,
    input  logic        prog_we,
    input  logic        prom_we,
    input  logic        prog_rdy,
    input  logic        cfg_we,
    input  logic        cps2_key_we,
    input  logic [1:0]  joymode,
    input  logic [15:0] dump_din,
    input  logic        dump_we,
    output int          errors,
    output int          pending,
    output int          n_prog,
    output int          n_prom,
    output int          n_reads
);
    import rom_load_pkg::*;

    prog_req_t   exp_q[$];
    prog_req_t   e;
    logic [7:0]  hdr[64];      // header copy seen on the host bus
    logic        prev_we;
    logic        prev_rdy;
    logic        prev_dl;
    logic        exp_cfg;
    logic        exp_key;
    logic [1:0]  exp_joy;
    logic        nv_pend;
    logic [15:0] nv_exp;
    logic [15:0] nv_known;     // lanes written so far
    logic [15:0] rd_word;
    logic [7:0]  rd_byte;

    // eeprom contents as the testbench memory model holds them
    function automatic logic [15:0] nv_word(input logic [6:0] a);
        return {{1'b1, a} ^ 8'h3c, {a, 1'b0} ^ 8'ha5};
    endfunction

    function automatic logic [7:0] expect_unscramble(input logic [7:0] raw);
        logic [7:0] r;
        r = 8'd0;
        for (int i = 0; i < 8; i++) begin
            r = r ^ (raw[i] ? scramble_set_mask[i] : scramble_clr_mask[i]);
        end
        return r;
    endfunction

    function automatic prog_req_t expect_req(input logic [24:0] bulk, input logic [7:0] raw);
        prog_req_t   r;
        logic [15:0] p_snd;
        logic [15:0] p_pcm;
        logic [15:0] p_gfx;
        logic [15:0] p_qs;
        logic [15:0] kb;
        logic [24:0] base;
        logic [24:0] rel;
        logic [21:0] offs;
        logic        hit;
        p_snd = {hdr[1], hdr[0]};
        p_pcm = {hdr[3], hdr[2]};
        p_gfx = {hdr[5], hdr[4]};
        p_qs  = {hdr[7], hdr[6]};
        kb    = 16'(bulk >> 10);
        r     = '0;
        r.bank = 2'd1;
        base  = '0;
        offs  = cpu_offset;
        if (kb < p_snd) begin
            r.region = reg_cpu;
            r.bank   = 2'd0;
        end else if (kb < p_pcm) begin
            r.region = reg_snd;
            base     = 25'(p_snd) * 25'd1024;
            offs     = snd_offset;
        end else if (kb < p_gfx) begin
            r.region = reg_pcm;
            base     = 25'(p_pcm) * 25'd1024;
            offs     = pcm_offset;
        end else if (kb < p_qs) begin
            r.region = reg_gfx;
            r.bank   = 2'd3;
            base     = 25'(p_gfx) * 25'd1024;
            offs     = gfx_offset;
        end else begin
            r.region = reg_qsnd;
            base     = 25'(p_qs) * 25'd1024;
        end
        rel = bulk - base;
        if (r.region == reg_qsnd) r.addr = 22'(rel[12:0]);
        else r.addr = 22'(rel >> 1) + offs;
        r.mask = bulk[0] ? 2'b01 : 2'b10;
        hit = hdr[39][7] && r.region == reg_cpu && bulk[19] && (bulk[0] ^ hdr[39][6]);
        r.data = hit ? expect_unscramble(raw) : raw;
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    initial begin
        errors  = 0;
        n_prog  = 0;
        n_prom  = 0;
        n_reads = 0;
        pending = 0;
        for (int i = 0; i < 64; i++) hdr[i] = 8'd0;
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prev_we  = 1'b0;
            prev_rdy = 1'b0;
            prev_dl  = 1'b0;
            exp_cfg  = 1'b0;
            exp_key  = 1'b0;
            exp_joy  = 2'd0;
            nv_pend  = 1'b0;
            nv_known = '0;
            nv_exp   = '0;
        end else begin
            check("cfg_we", cfg_we, exp_cfg);
            check("cps2_key_we", cps2_key_we, exp_key);
            check("joymode", joymode, exp_joy);
            if (prev_we && !prev_rdy && prev_dl && !prog_we) begin
                $display("prog_we was released at %0t before prog_rdy came", $time);
                errors++;
            end
            if (prog_we && !prev_we) begin
                n_prog++;
                if (exp_q.size() == 0) begin
                    $display("prog_we rose at %0t with no byte outstanding", $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check("prog_we region", prog_we && e.region != reg_qsnd, 1'b1);
                    check("prog_addr", prog_addr, e.addr);
                    check("prog_ba", prog_ba, e.bank);
                    check("prog_mask", prog_mask, e.mask);
                    check("prog_data", prog_data, {2{e.data}});
                end
            end
            if (prom_we) begin
                n_prom++;
                check("prog_we during prom_we", prog_we, 1'b0);
                if (exp_q.size() == 0) begin
                    $display("prom_we rose at %0t with no byte outstanding", $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check("prom_we region", e.region, reg_qsnd);
                    check("prom addr", prog_addr, e.addr);
                    check("prom data", prog_data[7:0], e.data);
                end
            end
            check("dump_we", dump_we, nv_pend);
            if (nv_pend) check("dump_din", dump_din & nv_known, nv_exp & nv_known);
            if (ioctl_ram && !ioctl_wr) begin
                n_reads++;
                rd_word = nv_word(ioctl_addr[7:1]);
                rd_byte = ioctl_addr[0] ? rd_word[15:8] : rd_word[7:0];
                check("ioctl_data2sd", ioctl_data2sd, rd_byte);
            end

            // next-cycle expectations from this cycle's host write
            exp_cfg = ioctl_wr && !ioctl_ram && ioctl_addr >= 8 && ioctl_addr <= 39;
            exp_key = ioctl_wr && !ioctl_ram && ioctl_addr >= 44 && ioctl_addr <= 63;
            nv_pend = ioctl_wr && ioctl_ram;
            if (nv_pend) begin
                if (ioctl_addr[0]) begin
                    nv_exp[15:8]   = ioctl_data;
                    nv_known[15:8] = 8'hff;
                end else begin
                    nv_exp[7:0]   = ioctl_data;
                    nv_known[7:0] = 8'hff;
                end
            end
            if (ioctl_wr && !ioctl_ram) begin
                if (ioctl_addr < 64) begin
                    hdr[ioctl_addr[5:0]] = ioctl_data;
                    if (ioctl_addr == 40) exp_joy = ioctl_data[1:0];
                end else begin
                    exp_q.push_back(expect_req(ioctl_addr - 25'd64, ioctl_data));
                end
            end
            prev_we  = prog_we;
            prev_rdy = prog_rdy;
            prev_dl  = downloading;
            pending  = exp_q.size();
        end
    end

endmodule

/* sim/tb_rom_loader.sv */
// testbench top for the rom loader, streams two random images and an eeprom dump through the DUT
module tb_rom_loader;
    import rom_load_pkg::*;

    typedef struct packed {
        logic [1:0]  kind;   // 0 rom byte, 1 download gap, 2 nv write, 3 nv read
        logic        ack;    // wait for the sdram ack
        logic [24:0] addr;
        logic [7:0]  data;
    } step_t;

    logic        clk;
    logic        arst_n;
    logic        downloading;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_data;
    logic        ioctl_wr;
    logic        ioctl_ram;
    logic [7:0]  ioctl_data2sd;
    logic [21:0] prog_addr;
    logic [15:0] prog_data;
    logic [1:0]  prog_mask;
    logic [1:0]  prog_ba;
    logic        prog_we;
    logic        prom_we;
    logic        prog_rdy;
    logic        cfg_we;
    logic        cps2_key_we;
    logic [1:0]  joymode;
    logic [15:0] dump_din;
    logic [15:0] dump_dout;
    logic [eeprom_aw-1:0] dump_addr;
    logic        dump_we;
    logic        rdy_busy;
    logic [2:0]  rdy_dly;

    step_t steps[$];
    int    limit_cycles = 0;
    int    exp_prog = 0;
    int    exp_prom = 0;
    int    late_errors = 0;   // failures found after the stream ends
    int    errors;
    int    pending;
    int    n_prog;
    int    n_prom;
    int    n_reads;

    clock_gen u_clk (.clk, .arst_n);

    rom_loader_top u_dut (.*);

    rom_loader_checker u_chk (.*);

    function automatic logic [15:0] nv_word(input logic [6:0] a);
        return {{1'b1, a} ^ 8'h3c, {a, 1'b0} ^ 8'ha5};
    endfunction

    assign dump_dout = nv_word(dump_addr);   // eeprom model

    // sdram model, ack 1 to 4 cycles after prog_we
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_rdy <= 1'b0;
            rdy_busy <= 1'b0;
            rdy_dly  <= 3'd0;
        end else begin
            prog_rdy <= 1'b0;
            if (prog_we && !rdy_busy && !prog_rdy) begin
                rdy_busy <= 1'b1;
                rdy_dly  <= 3'($urandom_range(0, 3));
            end else if (rdy_busy) begin
                if (rdy_dly == 0) begin
                    prog_rdy <= 1'b1;
                    rdy_busy <= 1'b0;
                end else begin
                    rdy_dly <= rdy_dly - 3'd1;
                end
            end
        end
    end

    task automatic add_step(input int kind, input bit ack, input int addr, input int data);
        steps.push_back(step_t'{2'(kind), ack, 25'(addr), 8'(data)});
        if (ack) exp_prog++;
    endtask

    task automatic build_image(input bit flag);
        logic [15:0] p[4];
        logic [7:0]  b;
        int          n;
        p[0] = 16'd520 + 16'($urandom % 64);    // cpu reaches past bulk bit 19
        for (int k = 1; k < 4; k++) p[k] = p[k-1] + 16'd1 + 16'($urandom % 4);
        for (int i = 0; i < 64; i++) begin
            if (i < 8) b = p[i/2][8*(i%2) +: 8];
            else b = 8'($urandom);
            if (i == 39) b[7] = flag;
            add_step(0, 0, i, b);
        end
        n = 4 + $urandom % 5;
        for (int i = 0; i < n; i++) begin
            add_step(0, 1, 64 + i, $urandom);
            add_step(0, 1, 64 + 32'h80000 + i, $urandom);
        end
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < n; i++) add_step(0, 1, 64 + p[k] * 1024 + i, $urandom);
        end
        for (int i = 0; i < n; i++) begin
            add_step(0, 0, 64 + p[3] * 1024 + i, $urandom);   // internal rom
            exp_prom++;
        end
        add_step(1, 0, 0, 0);
    endtask

    task automatic play(input step_t s);
        @(posedge clk);
        if (s.kind == 2'd1) begin
            downloading <= 1'b0;
            repeat (4) @(posedge clk);
            downloading <= 1'b1;
        end else begin
            ioctl_addr <= s.addr;
            ioctl_data <= s.data;
            ioctl_ram  <= s.kind != 2'd0;
            ioctl_wr   <= s.kind != 2'd3;
            @(posedge clk);
            ioctl_wr <= 1'b0;
            if (s.ack) begin
                do @(posedge clk); while (!prog_rdy);
            end
        end
    endtask

    initial begin
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        ioctl_ram   = 1'b0;
        void'($urandom(32'hc4b5));
        build_image(1'b1);
        build_image(1'b0);
        for (int i = 0; i < 16; i++) add_step(2, 0, i, $urandom);
        for (int i = 0; i < 24; i++) add_step(3, 0, (i * 11) % 256, 0);
        limit_cycles = steps.size() * 10 + 1000;
        wait (arst_n);
        repeat (2) @(posedge clk);
        downloading <= 1'b1;
        foreach (steps[i]) play(steps[i]);
        repeat (10) @(posedge clk);
        if (pending != 0) begin
            $display("%0d expected writes never reached the DUT outputs", pending);
            late_errors++;
        end
        if (n_prog != exp_prog || n_prom != exp_prom) begin
            $display("write counts differ, expected %0d sdram and %0d internal rom",
                     exp_prog, exp_prom);
            late_errors++;
        end
        if (n_reads == 0) begin
            $display("no eeprom read-back was checked");
            late_errors++;
        end
        $display("prog writes %0d, prom writes %0d, reads %0d, errors %0d",
                 n_prog, n_prom, n_reads, errors + late_errors);
        if (errors + late_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", limit_cycles);
        $display("Verification failed");
        $finish;
    end

endmodule

/* sources.f */
source/rom_load_pkg.sv
source/rom_header_regs.sv
source/rom_region_map.sv
source/byte_unscramble.sv
source/rom_prog_writer.sv
source/nvram_dump_port.sv
source/rom_loader_top.sv
sim/clock_gen.sv
sim/rom_loader_checker.sv
sim/tb_rom_loader.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the rom loader testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal -f sources.f \
    --top-module tb_rom_loader --Mdir obj_dir -o tb_rom_loader
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_rom_loader > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi

if ! grep -q "Verification passed" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0
